// ==== bch_pkg.sv ====
package bch_pkg;

	localparam int BCH_M = 4;                      // Bits per field symbol.
	localparam int BCH_N = 15;                     // Codeword length.
	localparam int BCH_T = 2;                      // Correctable errors.
	localparam int SIGMA_SZ = (BCH_T + 1) * BCH_M; // Coefficient 0 in the low nibble.
	localparam int CNT_W = $clog2(BCH_N + 1);      // Holds 0 to N.
	localparam int FIFO_DEPTH = 4;

	// x^4 + x + 1, including the top bit.
	localparam logic [BCH_M:0] PRIM_POLY = 5'b10011;

	typedef logic [BCH_M-1:0] gf_t;
	typedef logic [BCH_N-1:0] codeword_t;          // Bit i is position i.

	typedef struct packed {
		logic err;                                 // Position in error.
		logic last;                                // Position N-1.
		logic uncorrectable;                       // Valid with last only.
	} err_item_t;

	// Divide by alpha. An odd element first picks up the polynomial.
	function automatic gf_t gf_mul_alpha_inv(gf_t a);
		logic [BCH_M:0] t;
		t = {1'b0, a} ^ (a[0] ? PRIM_POLY : '0);
		return t[BCH_M:1];
	endfunction

	// Shift-and-add multiply, MSB of b first.
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		logic [BCH_M:0] acc;
		acc = '0;
		for (int i = BCH_M - 1; i >= 0; i--) begin
			acc = {acc[BCH_M-1:0], 1'b0};
			if (acc[BCH_M])
				acc = acc ^ PRIM_POLY;             // Reduce.
			if (b[i])
				acc[BCH_M-1:0] = acc[BCH_M-1:0] ^ a;
		end
		return acc[BCH_M-1:0];
	endfunction

endpackage

// ==== bch_chien_search.sv ====
`timescale 1ns/10ps

module bch_chien_search import bch_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [SIGMA_SZ-1:0] sigma,
	input  logic                sigma_valid,
	output logic                sigma_ready,
	output err_item_t           item,
	output logic                item_valid,
	input  logic                item_ready
);

	gf_t              term [BCH_T+1];      // Coefficient j times alpha^(-i*j).
	gf_t              term_step [BCH_T+1];
	gf_t              sum;
	logic             busy;
	logic [CNT_W-1:0] pos;                 // Position of the current item.
	logic [CNT_W-1:0] root_cnt;
	logic [CNT_W-1:0] root_cnt_next;
	logic [CNT_W-1:0] degree;
	logic [CNT_W-1:0] sigma_degree;
	logic             is_root;
	logic             is_last;
	logic             accept;
	logic             advance;

	assign sigma_ready = !busy;
	assign accept = sigma_valid && sigma_ready;
	assign item_valid = busy;
	assign advance = item_valid && item_ready;

	// Highest nonzero coefficient of the incoming sigma.
	always_comb begin
		sigma_degree = '0;
		for (int j = 1; j <= BCH_T; j++) begin
			if (sigma[j*BCH_M +: BCH_M] != '0)
				sigma_degree = CNT_W'(j);
		end
	end

	// Term j moves on by alpha^-j, done as j single steps.
	always_comb begin
		for (int j = 0; j <= BCH_T; j++) begin
			term_step[j] = term[j];
			for (int k = 0; k < j; k++)
				term_step[j] = gf_mul_alpha_inv(term_step[j]);
		end
	end

	always_comb begin
		sum = '0;
		for (int j = 0; j <= BCH_T; j++)
			sum = sum ^ term[j];               // sigma(alpha^-pos).
	end

	assign is_root = (sum == '0);
	assign is_last = (pos == CNT_W'(BCH_N - 1));
	assign root_cnt_next = root_cnt + CNT_W'(is_root);

	// Root count must match the degree, else sigma has roots outside the field.
	assign item = '{
		err: is_root,
		last: is_last,
		uncorrectable: is_last && (root_cnt_next != degree)
	};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			pos <= '0;
			root_cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			pos <= '0;
			root_cnt <= '0;
		end else if (advance) begin
			busy <= !is_last;                  // Free again after position N-1.
			pos <= pos + 1'b1;
			root_cnt <= root_cnt_next;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			degree <= sigma_degree;
			for (int j = 0; j <= BCH_T; j++)
				term[j] <= sigma[j*BCH_M +: BCH_M];
		end else if (advance) begin
			term <= term_step;
		end
	end

endmodule

// ==== bch_stream_fifo.sv ====
`timescale 1ns/10ps

module bch_stream_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH = 4
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Wraps at DEPTH, so any depth works.
	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = (count != CNT_W'(DEPTH)); // Drops when full.
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;                     // Both or neither, no change.
			endcase
		end
	end

endmodule

// ==== bch_error_correct.sv ====
`timescale 1ns/10ps

module bch_error_correct import bch_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  err_item_t item,
	input  logic      item_valid,
	output logic      item_ready,
	input  codeword_t codeword,
	input  logic      codeword_valid,
	output logic      codeword_ready,
	output codeword_t corrected,
	output logic      uncorrectable,
	output logic      out_valid,
	input  logic      out_ready
);

	codeword_t mask;
	codeword_t mask_next;
	logic      last_item;
	logic      take;
	logic      finish;

	assign last_item = item_valid && item.last;

	// Stall while a result is held, and hold the last item until its word is there.
	assign item_ready = !out_valid && (!last_item || codeword_valid);
	assign codeword_ready = !out_valid && last_item;
	assign take = item_valid && item_ready;
	assign finish = take && item.last;    // Codeword pops in this cycle too.

	// Position 0 comes first and has shifted down to bit 0 by the end.
	assign mask_next = {item.err, mask[BCH_N-1:1]};

	always_ff @(posedge clk) begin
		if (take)
			mask <= mask_next;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (finish)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;             // Result taken.
	end

	always_ff @(posedge clk) begin
		if (finish) begin
			corrected <= codeword ^ mask_next;
			uncorrectable <= item.uncorrectable;
		end
	end

endmodule

// ==== bch_error_locator.sv ====
`timescale 1ns/10ps

module bch_error_locator import bch_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [SIGMA_SZ-1:0] sigma,
	input  codeword_t           codeword,
	input  logic                in_valid,
	output logic                in_ready,
	output codeword_t           corrected,
	output logic                uncorrectable,
	output logic                out_valid,
	input  logic                out_ready
);

	logic      search_ready;
	logic      cw_in_ready;
	err_item_t search_item;
	logic      search_item_valid;
	logic      search_item_ready;
	err_item_t fifo_item;
	logic      fifo_item_valid;
	logic      fifo_item_ready;
	codeword_t fifo_codeword;
	logic      fifo_codeword_valid;
	logic      fifo_codeword_ready;

	// Search and codeword FIFO take each input together or not at all.
	assign in_ready = search_ready && cw_in_ready;

	bch_chien_search u_search (
		.clk(clk),
		.arst_n(arst_n),
		.sigma(sigma),
		.sigma_valid(in_valid && cw_in_ready),
		.sigma_ready(search_ready),
		.item(search_item),
		.item_valid(search_item_valid),
		.item_ready(search_item_ready)
	);

	bch_stream_fifo #(
		.payload_t(err_item_t),
		.DEPTH(FIFO_DEPTH)
	) u_err_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.in_data(search_item),
		.in_valid(search_item_valid),
		.in_ready(search_item_ready),
		.out_data(fifo_item),
		.out_valid(fifo_item_valid),
		.out_ready(fifo_item_ready)
	);

	bch_stream_fifo #(
		.payload_t(codeword_t),
		.DEPTH(FIFO_DEPTH)
	) u_cw_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.in_data(codeword),
		.in_valid(in_valid && search_ready),
		.in_ready(cw_in_ready),
		.out_data(fifo_codeword),
		.out_valid(fifo_codeword_valid),
		.out_ready(fifo_codeword_ready)
	);

	bch_error_correct u_correct (
		.clk(clk),
		.arst_n(arst_n),
		.item(fifo_item),
		.item_valid(fifo_item_valid),
		.item_ready(fifo_item_ready),
		.codeword(fifo_codeword),
		.codeword_valid(fifo_codeword_valid),
		.codeword_ready(fifo_codeword_ready),
		.corrected(corrected),
		.uncorrectable(uncorrectable),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = !clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;                          // Released on a falling edge.
	end

endmodule

// ==== bch_error_locator_assertions.sv ====
`timescale 1ns/10ps

module bch_error_locator_assertions import bch_pkg::*; (
	input logic                clk,
	input logic                arst_n,
	input logic [SIGMA_SZ-1:0] sigma,
	input logic                in_valid,
	input logic                in_ready,
	input codeword_t           corrected,
	input logic                out_valid,
	input logic                out_ready
);

	int failures = 0;                          // Count of failed assertions.

	input_held: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid && !in_ready |=> in_valid && $stable(sigma))
		else begin
			failures++;
			$error("in_valid dropped or sigma changed before acceptance");
		end

	output_held: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(corrected))
		else begin
			failures++;
			$error("out_valid dropped or corrected changed before out_ready");
		end

	reset_clears: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else begin
			failures++;
			$error("out_valid high while reset is asserted");
		end

endmodule

bind bch_error_locator bch_error_locator_assertions u_assertions (
	.clk(clk),
	.arst_n(arst_n),
	.sigma(sigma),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.corrected(corrected),
	.out_valid(out_valid),
	.out_ready(out_ready)
);

// ==== bch_error_locator_tb.sv ====
`timescale 1ns/10ps

module bch_error_locator_tb import bch_pkg::*; ();

	localparam int  TIMEOUT = 200;
	localparam gf_t ALPHA = 4'h2;
	localparam gf_t ALPHA_INV = 4'h9;          // alpha^14 = alpha^3 + 1.

	logic                clk;
	logic                por_n;
	logic                test_rst_n;
	logic                arst_n;
	logic [SIGMA_SZ-1:0] sigma;
	codeword_t           codeword;
	logic                in_valid;
	logic                in_ready;
	codeword_t           corrected;
	logic                uncorrectable;
	logic                out_valid;
	logic                out_ready;

	integer    seed;
	int        mismatches;
	int        timeouts;
	logic      random_ready;
	logic      hold_output;
	codeword_t exp_word [$];
	logic      exp_unc [$];

	assign arst_n = por_n && test_rst_n;

	tb_clock_gen clock_gen (.clk(clk), .rst_n(por_n));

	bch_error_locator UUT (
		.clk(clk),
		.arst_n(arst_n),
		.sigma(sigma),
		.codeword(codeword),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.corrected(corrected),
		.uncorrectable(uncorrectable),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	function automatic gf_t alpha_pow(int e);
		gf_t x;
		x = 4'h1;
		for (int i = 0; i < e; i++)
			x = gf_mul(x, ALPHA);
		return x;
	endfunction

	// Flip every root position of sigma in the received word.
	function automatic codeword_t bch_ref(logic [SIGMA_SZ-1:0] s, codeword_t rx, output logic unc);
		gf_t       x;
		gf_t       val;
		int        roots;
		int        deg;
		codeword_t word;
		x = 4'h1;
		roots = 0;
		word = rx;
		deg = (s[11:8] != 4'h0) ? 2 : ((s[7:4] != 4'h0) ? 1 : 0);
		for (int i = 0; i < BCH_N; i++) begin
			val = s[3:0] ^ gf_mul(s[7:4], x) ^ gf_mul(s[11:8], gf_mul(x, x));
			if (val == 4'h0) begin
				word[i] = !word[i];
				roots++;
			end
			x = gf_mul(x, ALPHA_INV);          // Now alpha^-(i+1).
		end
		unc = (roots != deg);
		return word;
	endfunction

	// Sigma with 0, 1 or 2 random distinct error positions.
	function automatic logic [SIGMA_SZ-1:0] random_sigma(int errors);
		int  e1;
		int  e2;
		gf_t a1;
		gf_t a2;
		e1 = $unsigned($random(seed)) % BCH_N;
		e2 = (e1 + 1 + $unsigned($random(seed)) % (BCH_N - 1)) % BCH_N;
		a1 = alpha_pow(e1);
		a2 = alpha_pow(e2);
		if (errors == 0)
			return 12'h001;
		else if (errors == 1)
			return {4'h0, a1, 4'h1};
		return {gf_mul(a1, a2), a1 ^ a2, 4'h1};
	endfunction

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			mismatches++;
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
		timeouts++;
	endtask

	// Called on a falling edge; returns one falling edge after the transfer.
	task automatic send_case(logic [SIGMA_SZ-1:0] s, codeword_t cw);
		logic      unc;
		codeword_t word;
		int        t;
		word = bch_ref(s, cw, unc);
		exp_word.push_back(word);
		exp_unc.push_back(unc);
		sigma = s;
		codeword = cw;
		in_valid = 1'b1;
		t = 0;
		while (!in_ready && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!in_ready)
			report_timeout("input acceptance");
		@(negedge clk);
	endtask

	task automatic wait_drained();
		int t;
		int left;
		t = 0;
		left = exp_word.size();
		while (exp_word.size() != 0 && t < TIMEOUT) begin
			@(negedge clk);
			if (exp_word.size() < left) begin
				t = 0;
				left = exp_word.size();
			end else begin
				t++;
			end
		end
		if (exp_word.size() != 0) begin
			report_timeout("result output");
			exp_word.delete();
			exp_unc.delete();
		end
	endtask

	// Compare process; a transfer is decided here on the falling edge.
	initial begin
		forever begin
			@(negedge clk);
			out_ready = hold_output ? 1'b0 : (random_ready ? 1'($random(seed)) : 1'b1);
			if (arst_n && out_valid && out_ready) begin
				if (exp_word.size() == 0) begin
					$display("Error: a result arrived with no case outstanding");
					mismatches++;
				end else begin
					check_value("corrected", corrected, exp_word.pop_front());
					check_value("uncorrectable", uncorrectable, exp_unc.pop_front());
				end
			end
		end
	end

	initial begin
		int        t;
		codeword_t cw;
		logic      unc_chk;
		seed = 71;
		mismatches = 0;
		timeouts = 0;
		random_ready = 1'b0;
		hold_output = 1'b0;
		test_rst_n = 1'b1;
		sigma = 12'h001;
		codeword = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		t = 0;
		while (arst_n !== 1'b1 && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (arst_n !== 1'b1)
			report_timeout("reset release");
		@(negedge clk);
		check_value("out_valid", out_valid, 0);
		check_value("in_ready", in_ready, 1);

		send_case(random_sigma(0), codeword_t'($random(seed)));
		send_case(random_sigma(1), codeword_t'($random(seed)));
		for (int k = 0; k < 40; k++)
			send_case(random_sigma(2), codeword_t'($random(seed)));
		in_valid = 1'b0;
		wait_drained();

		// x^2 + x + alpha^3 has no roots in GF(16).
		cw = codeword_t'($random(seed));
		void'(bch_ref(12'h118, cw, unc_chk));
		check_value("reference uncorrectable", unc_chk, 1);
		send_case(12'h118, cw);
		in_valid = 1'b0;
		wait_drained();

		random_ready = 1'b1;
		for (int k = 0; k < 30; k++)
			send_case(random_sigma(k % 3), codeword_t'($random(seed)));
		in_valid = 1'b0;
		wait_drained();
		random_ready = 1'b0;

		// Two results in flight when reset hits.
		hold_output = 1'b1;
		send_case(random_sigma(2), codeword_t'($random(seed)));
		send_case(random_sigma(1), codeword_t'($random(seed)));
		in_valid = 1'b0;
		repeat (4) @(negedge clk);
		test_rst_n = 1'b0;
		repeat (3) @(negedge clk);
		test_rst_n = 1'b1;
		exp_word.delete();
		exp_unc.delete();
		@(negedge clk);
		check_value("out_valid", out_valid, 0);
		check_value("in_ready", in_ready, 1);
		hold_output = 1'b0;
		send_case(random_sigma(2), codeword_t'($random(seed)));
		in_valid = 1'b0;
		wait_drained();

		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, UUT.u_assertions.failures);
		if (mismatches + timeouts + UUT.u_assertions.failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== sim.f ====
bch_pkg.sv
bch_chien_search.sv
bch_stream_fifo.sv
bch_error_correct.sv
bch_error_locator.sv
tb_clock_gen.sv
bch_error_locator_assertions.sv
bch_error_locator_tb.sv

// ==== Bender.yml ====
package:
  name: bch_error_locator

sources:
  - bch_pkg.sv
  - bch_chien_search.sv
  - bch_stream_fifo.sv
  - bch_error_correct.sv
  - bch_error_locator.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - bch_error_locator_assertions.sv
      - bch_error_locator_tb.sv
